// ==== hdl/instBufferPkg.sv ====
`default_nettype none

package instBufferPkg;

  // number of decode lanes that can deliver an instruction in one cycle
  localparam int FETCH_WIDTH = 4;

  // dispatch always takes exactly this many instructions from the head
  localparam int DISPATCH_WIDTH = 2;

  // circular buffer size, a power of two so pointers wrap for free
  localparam int QUEUE_DEPTH = 16;
  localparam int QUEUE_LOG = 4;

  // width of one decoded instruction as it leaves decode
  localparam int PACKET_WIDTH = 32;

  // the top bit of a packet marks a control-transfer instruction
  localparam int BRANCH_BIT = 31;

  // bits needed to name one of the decode lanes
  localparam int LANE_LOG = 2;

  // one decoded instruction
  typedef logic [PACKET_WIDTH-1:0] packet_t;

  // one bit per decode lane, used for valids and write enables
  typedef logic [FETCH_WIDTH-1:0] laneVec_t;

  // index of a decode lane feeding a write port
  typedef logic [LANE_LOG-1:0] laneIdx_t;

  // head or tail index, wraps modulo QUEUE_DEPTH
  typedef logic [QUEUE_LOG-1:0] queuePtr_t;

  // occupancy needs one more bit than a pointer to tell full from empty
  typedef logic [QUEUE_LOG:0] queueCount_t;

  // branches found in the dispatch window, 0 up to DISPATCH_WIDTH
  typedef logic [1:0] branchCount_t;

endpackage

`default_nettype wire

// ==== hdl/instQueueIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface instQueueIf
  import instBufferPkg::*;
();

  // one enable per write port, ports are filled from port 0 upward
  laneVec_t writeEnable;

  // entry written by each write port, tail plus the port number
  queuePtr_t writeAddr [FETCH_WIDTH];

  // decode lane whose packet each write port stores
  laneIdx_t writeLane [FETCH_WIDTH];

  // entries shown on the dispatch ports, head and the ones after it
  queuePtr_t readAddr [DISPATCH_WIDTH];

  // the counter computes all addressing
  modport counter (
    output writeEnable,
    output writeAddr,
    output writeLane,
    output readAddr
  );

  // the storage only follows what the counter asks for
  modport storage (
    input writeEnable,
    input writeAddr,
    input writeLane,
    input readAddr
  );

endinterface

`default_nettype wire

// ==== hdl/occupancyCounter.sv ====
`timescale 1ns/10ps
`default_nettype none

module occupancyCounter
  import instBufferPkg::*;
(
  input  logic        clk,
  input  logic        rstN_i,
  input  logic        flush_i,
  input  logic        stall_i,
  input  logic        decodeReady_i,
  input  laneVec_t    decodedVector_i,
  instQueueIf.counter qIf,
  output logic        instBufferReady_o,
  output logic        stallFetch_o
);

  // oldest waiting instruction
  queuePtr_t headPtr;

  // first free entry
  queuePtr_t tailPtr;

  // number of waiting instructions
  queueCount_t instCount;

  // lanes that are really written this cycle
  laneVec_t acceptVec;

  // how many lanes are written, 0 up to FETCH_WIDTH
  logic [LANE_LOG:0] acceptCount;

  // dispatch takes a full window this cycle
  logic dispatchFire;

  // occupancy after this cycle's intake and dispatch
  queueCount_t countNext;

  // enough instructions for a full dispatch window
  assign instBufferReady_o = (instCount >= queueCount_t'(DISPATCH_WIDTH));

  // stop fetch once a full decode group might no longer fit
  assign stallFetch_o = (instCount > queueCount_t'(QUEUE_DEPTH - FETCH_WIDTH));

  // offered lanes are dropped as a whole while fetch is stalled,
  // fetch holds them and offers them again later
  assign acceptVec = decodedVector_i & {FETCH_WIDTH{decodeReady_i & ~stallFetch_o}};

  assign dispatchFire = instBufferReady_o & ~stall_i;

  // lane compaction
  // write port k gets the k-th accepted lane counted from lane 0,
  // so the accepted instructions keep their program order in the queue
  always_comb begin : compactLanes
    logic [LANE_LOG:0] portIdx;
    portIdx = '0;
    qIf.writeEnable = '0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      qIf.writeLane[k] = laneIdx_t'(k);
    end
    for (int l = 0; l < FETCH_WIDTH; l++) begin
      if (acceptVec[l]) begin
        qIf.writeEnable[portIdx[LANE_LOG-1:0]] = 1'b1;
        qIf.writeLane[portIdx[LANE_LOG-1:0]] = laneIdx_t'(l);
        portIdx = portIdx + 1'b1;
      end
    end
    acceptCount = portIdx;
  end

  // write ports go to consecutive entries starting at the tail,
  // the pointer width makes the addresses wrap around the buffer
  for (genvar k = 0; k < FETCH_WIDTH; k++) begin : genWriteAddr
    assign qIf.writeAddr[k] = tailPtr + queuePtr_t'(k);
  end

  // the dispatch window always starts at the head
  for (genvar d = 0; d < DISPATCH_WIDTH; d++) begin : genReadAddr
    assign qIf.readAddr[d] = headPtr + queuePtr_t'(d);
  end

  // intake and dispatch can happen in the same cycle
  always_comb begin
    countNext = instCount + queueCount_t'(acceptCount);
    if (dispatchFire) begin
      countNext = countNext - queueCount_t'(DISPATCH_WIDTH);
    end
  end

  // a flush after a misprediction throws away everything at once
  // and wins over intake and dispatch in the same cycle
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else if (flush_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      tailPtr <= tailPtr + queuePtr_t'(acceptCount);
      // head holds under stall_i so the window stays on the outputs
      if (dispatchFire) begin
        headPtr <= headPtr + queuePtr_t'(DISPATCH_WIDTH);
      end
      instCount <= countNext;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/instQueueStorage.sv ====
`timescale 1ns/10ps
`default_nettype none

module instQueueStorage
  import instBufferPkg::*;
(
  input  logic               clk,
  input  logic               rstN_i,
  instQueueIf.storage        qIf,
  input  packet_t            decodedPacket_i [FETCH_WIDTH],
  output packet_t            decodedPacket_o [DISPATCH_WIDTH],
  output branchCount_t       branchCount_o
);

  // the buffer entries themselves
  packet_t entry [QUEUE_DEPTH];

  // packet each write port stores after lane steering
  packet_t writeData [FETCH_WIDTH];

  // packets currently sitting at the read addresses
  packet_t readData [DISPATCH_WIDTH];

  // each write port picks the decode lane chosen by the counter, so the
  // valid lanes land in consecutive entries no matter where the gaps are
  always_comb begin
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      writeData[k] = decodedPacket_i[qIf.writeLane[k]];
    end
  end

  // every entry looks at all write ports and takes the one aimed at it
  // enabled ports always carry distinct addresses, so at most one matches
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      for (int e = 0; e < QUEUE_DEPTH; e++) begin
        entry[e] <= '0;
      end
    end else begin
      for (int e = 0; e < QUEUE_DEPTH; e++) begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
          if (qIf.writeEnable[k] && (qIf.writeAddr[k] == queuePtr_t'(e))) begin
            entry[e] <= writeData[k];
          end
        end
      end
    end
  end

  // read ports are plain muxes from the entries, no latency
  always_comb begin
    for (int d = 0; d < DISPATCH_WIDTH; d++) begin
      readData[d] = entry[qIf.readAddr[d]];
    end
  end

  assign decodedPacket_o = readData;

  // rename needs to know how many checkpoints the window will use,
  // so count the marked control-transfer instructions among the read packets
  always_comb begin : countBranches
    branchCount_t branchSum;
    branchSum = '0;
    for (int d = 0; d < DISPATCH_WIDTH; d++) begin
      branchSum = branchSum + branchCount_t'(readData[d][BRANCH_BIT]);
    end
    branchCount_o = branchSum;
  end

endmodule

`default_nettype wire

// ==== hdl/instBufferTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module instBufferTop
  import instBufferPkg::*;
(
  input  logic         clk,
  input  logic         rstN_i,

  // misprediction flush, empties the buffer
  input  logic         flush_i,

  // later stages cannot take a dispatch window this cycle
  input  logic         stall_i,

  // decode group on the lanes, one valid bit per lane
  input  logic         decodeReady_i,
  input  laneVec_t     decodedVector_i,
  input  packet_t      decodedPacket_i [FETCH_WIDTH],

  // back-pressure to fetch and decode
  output logic         stallFetch_o,

  // dispatch window, valid while instBufferReady_o is high
  output logic         instBufferReady_o,
  output packet_t      decodedPacket_o [DISPATCH_WIDTH],
  output branchCount_t branchCount_o
);

  // addressing from the counter to the storage
  instQueueIf qIf ();

  // pointers, occupancy, lane compaction and the ready and stall levels
  occupancyCounter counter (
    .clk               (clk),
    .rstN_i            (rstN_i),
    .flush_i           (flush_i),
    .stall_i           (stall_i),
    .decodeReady_i     (decodeReady_i),
    .decodedVector_i   (decodedVector_i),
    .qIf               (qIf.counter),
    .instBufferReady_o (instBufferReady_o),
    .stallFetch_o      (stallFetch_o)
  );

  // the packets skip the counter and go straight into the entries
  instQueueStorage storage (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .qIf             (qIf.storage),
    .decodedPacket_i (decodedPacket_i),
    .decodedPacket_o (decodedPacket_o),
    .branchCount_o   (branchCount_o)
  );

endmodule

`default_nettype wire

// ==== test/instBufferTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module instBufferTb
  import instBufferPkg::*;
();

  // longest any wait loop may run in clock cycles
  localparam int WAIT_LIMIT = 200;

  logic         clk;
  logic         rstN;
  logic         flush;
  logic         stall;
  logic         decodeReady;
  laneVec_t     decodedVector;
  packet_t      decodedPacket [FETCH_WIDTH];
  logic         stallFetch;
  logic         instBufferReady;
  packet_t      dispatchPacket [DISPATCH_WIDTH];
  branchCount_t branchCount;

  // reference queue whose front is the buffer head
  packet_t modelQ [$];

  int valueErrors;
  int timeoutErrors;

  instBufferTop dut (
    .clk               (clk),
    .rstN_i            (rstN),
    .flush_i           (flush),
    .stall_i           (stall),
    .decodeReady_i     (decodeReady),
    .decodedVector_i   (decodedVector),
    .decodedPacket_i   (decodedPacket),
    .stallFetch_o      (stallFetch),
    .instBufferReady_o (instBufferReady),
    .decodedPacket_o   (dispatchPacket),
    .branchCount_o     (branchCount)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic checkPacket(input string what, input packet_t got, input packet_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      valueErrors++;
    end
  endtask

  task automatic checkBranchCount(input string what, input branchCount_t got,
                                  input branchCount_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
      valueErrors++;
    end
  endtask

  task automatic checkLevel(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      valueErrors++;
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    timeoutErrors++;
  endtask

  // compare the levels and, when a window is up, the head pair with the model
  task automatic checkState();
    branchCount_t expBranch;
    logic expReady;
    expReady = (modelQ.size() >= DISPATCH_WIDTH);
    checkLevel("instBufferReady_o", instBufferReady, expReady);
    checkLevel("stallFetch_o", stallFetch, modelQ.size() > QUEUE_DEPTH - FETCH_WIDTH);
    if (expReady) begin
      expBranch = '0;
      for (int d = 0; d < DISPATCH_WIDTH; d++) begin
        checkPacket($sformatf("decodedPacket_o[%0d]", d), dispatchPacket[d], modelQ[d]);
        if (modelQ[d][BRANCH_BIT]) begin
          expBranch = expBranch + 2'd1;
        end
      end
      checkBranchCount("branchCount_o", branchCount, expBranch);
    end
  endtask

  // one clock cycle where inputs change at the falling edge and the model
  // follows the intake, dispatch and flush rules at the rising edge
  task automatic driveCycle(input laneVec_t vec, input laneVec_t branchMask,
                            input logic ready, input logic hold, input logic doFlush);
    packet_t pkt;
    logic fetchStalled;
    logic fire;
    decodeReady = ready;
    decodedVector = vec;
    stall = hold;
    flush = doFlush;
    for (int l = 0; l < FETCH_WIDTH; l++) begin
      pkt = $urandom;
      pkt[BRANCH_BIT] = branchMask[l];
      decodedPacket[l] = pkt;
    end
    fetchStalled = (modelQ.size() > QUEUE_DEPTH - FETCH_WIDTH);
    fire = (modelQ.size() >= DISPATCH_WIDTH) && !hold;
    @(posedge clk);
    if (doFlush) begin
      modelQ.delete();
    end else begin
      if (fire) begin
        for (int d = 0; d < DISPATCH_WIDTH; d++) begin
          void'(modelQ.pop_front());
        end
      end
      // accepted lanes join the tail in lane order and gaps leave no holes
      for (int l = 0; l < FETCH_WIDTH; l++) begin
        if (ready && vec[l] && !fetchStalled) begin
          modelQ.push_back(decodedPacket[l]);
        end
      end
    end
    @(negedge clk);
    checkState();
  endtask

  task automatic flushBuffer();
    driveCycle('0, '0, 1'b0, 1'b0, 1'b1);
  endtask

  // dispatch until the buffer no longer holds a full window
  task automatic drainWindow();
    int waited;
    waited = 0;
    while (instBufferReady === 1'b1 && waited < WAIT_LIMIT) begin
      driveCycle('0, '0, 1'b0, 1'b0, 1'b0);
      waited++;
    end
    if (instBufferReady === 1'b1) begin
      reportTimeout("the buffer to drain");
    end
  endtask

  task automatic resetDefaults();
    $display("after reset");
    checkLevel("instBufferReady_o", instBufferReady, 1'b0);
    checkLevel("stallFetch_o", stallFetch, 1'b0);
    checkBranchCount("branchCount_o", branchCount, 2'd0);
    // a lone instruction is not a full dispatch window
    driveCycle(4'b0100, '0, 1'b1, 1'b0, 1'b0);
    checkLevel("instBufferReady_o", instBufferReady, 1'b0);
    flushBuffer();
  endtask

  task automatic laneCompaction();
    $display("compaction and order");
    for (int n = 0; n < 40; n++) begin
      driveCycle(laneVec_t'($urandom), laneVec_t'($urandom), ($urandom % 4) != 0,
                 1'b0, 1'b0);
    end
    drainWindow();
    flushBuffer();
  endtask

  task automatic stallHold();
    packet_t heldPair [DISPATCH_WIDTH];
    $display("stall holds dispatch");
    driveCycle(4'hF, laneVec_t'($urandom), 1'b1, 1'b1, 1'b0);
    heldPair[0] = modelQ[0];
    heldPair[1] = modelQ[1];
    // intake keeps going under stall_i while the window stays put
    for (int n = 0; n < 3; n++) begin
      driveCycle(laneVec_t'($urandom), laneVec_t'($urandom), 1'b1, 1'b1, 1'b0);
      checkPacket("held decodedPacket_o[0]", dispatchPacket[0], heldPair[0]);
      checkPacket("held decodedPacket_o[1]", dispatchPacket[1], heldPair[1]);
    end
    // the first pair dispatched after release is the one that was held
    driveCycle('0, '0, 1'b0, 1'b0, 1'b0);
    drainWindow();
    flushBuffer();
  endtask

  task automatic fetchBackPressure();
    int waited;
    $display("fetch stall");
    waited = 0;
    while (stallFetch !== 1'b1 && waited < WAIT_LIMIT) begin
      driveCycle(laneVec_t'($urandom), laneVec_t'($urandom), 1'b1, 1'b1, 1'b0);
      waited++;
    end
    if (stallFetch !== 1'b1) begin
      reportTimeout("stallFetch_o to rise");
    end
    // lanes offered now are dropped and the drain shows none of them
    for (int n = 0; n < 3; n++) begin
      driveCycle(4'hF, laneVec_t'($urandom), 1'b1, 1'b1, 1'b0);
      checkLevel("stallFetch_o", stallFetch, 1'b1);
    end
    drainWindow();
    flushBuffer();
  endtask

  task automatic flushRecovery();
    $display("flush");
    driveCycle(4'hF, laneVec_t'($urandom), 1'b1, 1'b1, 1'b0);
    driveCycle(4'hF, laneVec_t'($urandom), 1'b1, 1'b1, 1'b0);
    // lanes offered with the flush are thrown away too
    driveCycle(4'hF, laneVec_t'($urandom), 1'b1, 1'b0, 1'b1);
    checkLevel("instBufferReady_o", instBufferReady, 1'b0);
    checkLevel("stallFetch_o", stallFetch, 1'b0);
    driveCycle(4'b1011, laneVec_t'($urandom), 1'b1, 1'b1, 1'b0);
    driveCycle(4'b0110, laneVec_t'($urandom), 1'b1, 1'b1, 1'b0);
    drainWindow();
    flushBuffer();
  endtask

  task automatic branchCounting();
    $display("branch count");
    // queue becomes plain plain branch branch branch plain
    driveCycle(4'hF, 4'b1100, 1'b1, 1'b1, 1'b0);
    driveCycle(4'b0011, 4'b0001, 1'b1, 1'b1, 1'b0);
    checkBranchCount("branchCount_o window 0", branchCount, 2'd0);
    driveCycle('0, '0, 1'b0, 1'b0, 1'b0);
    checkBranchCount("branchCount_o window 1", branchCount, 2'd2);
    driveCycle('0, '0, 1'b0, 1'b0, 1'b0);
    checkBranchCount("branchCount_o window 2", branchCount, 2'd1);
    drainWindow();
    flushBuffer();
  endtask

  initial begin
    void'($urandom(32'h68ee_2e58));
    valueErrors = 0;
    timeoutErrors = 0;
    rstN = 1'b0;
    flush = 1'b0;
    stall = 1'b0;
    decodeReady = 1'b0;
    decodedVector = '0;
    for (int l = 0; l < FETCH_WIDTH; l++) begin
      decodedPacket[l] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    resetDefaults();
    laneCompaction();
    stallHold();
    fetchBackPressure();
    flushRecovery();
    branchCounting();

    $display("checks done with %0d value errors and %0d timeouts",
             valueErrors, timeoutErrors);
    if (valueErrors == 0 && timeoutErrors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/instBufferPkg.sv
hdl/instQueueIf.sv
hdl/occupancyCounter.sv
hdl/instQueueStorage.sv
hdl/instBufferTop.sv
test/instBufferTb.sv

// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing -j 0
TOP = instBufferTb
FILELIST = all.f

.PHONY: sim clean

# build, run, and fail unless the run reports a pass
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
